// File: verilog.f
design/isa_pkg.sv
design/core_bus_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/core_ctrl.sv
design/rv_core_top.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv

// File: dv/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int          CLK_PERIOD  = 20;
    localparam int          NUM_ROWS    = 6;
    localparam int          ROW_WORDS   = 8;
    localparam int          NUM_PASSES  = 2; // second pass draws other wait states
    localparam int          MEM_WORDS   = 64;
    localparam int          MAX_WAIT    = 3;
    localparam int          STOP_CYCLES = 6;
    localparam int          INST_CYCLES = 2 * (4 + 1) + 2; // fetch and data with 4 waits
    localparam int          ROW_CYCLES  = ROW_WORDS * INST_CYCLES + STOP_CYCLES + 4;
    localparam int          WATCHDOG_NS = NUM_PASSES * NUM_ROWS * ROW_CYCLES * CLK_PERIOD;
    localparam int unsigned SEED        = 32'h49a5_549b;

    logic                                clk = 1'b0;
    logic                                rst_n = 1'b0;
    logic [core_bus_pkg::ADDR_WIDTH-1:0] wb_adr;
    logic [core_bus_pkg::XLEN-1:0]       wb_wdata;
    logic [core_bus_pkg::SEL_WIDTH-1:0]  wb_sel;
    logic                                wb_we;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic [core_bus_pkg::XLEN-1:0]       wb_rdata = '0;
    logic                                wb_ack = 1'b0;
    logic                                retire;
    logic                                halted;
    logic                                illegal;

    logic [31:0] mem [MEM_WORDS];
    int          cur_row = 0;
    logic        busy = 1'b0;
    int          wait_left = 0;
    int          retire_cnt = 0;
    int          cyc_after_stop = 0;
    int          bad_req_cnt = 0;
    logic [31:0] last_st_adr = '0;
    logic [31:0] last_st_data = '0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    // eight words per row, loaded from address 0
    logic [31:0] code_tab [NUM_ROWS*ROW_WORDS] = '{
        // addi, add, sub, then sw of x2 - (x1 + x2)
        32'h0190_0093, 32'hff90_0113, 32'h0020_81b3, 32'h4031_0233,
        32'h0800_0293, 32'h0042_a223, 32'h0010_0073, 32'h0000_0000,
        // sw, lw back, addi to x0, add x3 + x0, sw
        32'h0800_0093, 32'h1230_0113, 32'h0020_a023, 32'h0000_a183,
        32'h0050_0013, 32'h0001_8233, 32'h0040_a423, 32'h0010_0073,
        // beq taken skips +16, beq not taken keeps +64
        32'h0030_0093, 32'h0030_0113, 32'h0020_8463, 32'h0100_8093,
        32'h0000_8463, 32'h0400_8093, 32'h0810_2823, 32'h0010_0073,
        // jal over addi, auipc, jalr to 21 lands on 20, sw of x1 + x4 at x2 + 0x9c
        32'h0080_016f, 32'h0011_0113, 32'h0000_1097, 32'h0150_0267,
        32'h0012_0213, 32'h0040_82b3, 32'h0851_2e23, 32'h0010_0073,
        // undefined opcode after one store
        32'h0550_0093, 32'h0810_2a23, 32'h0000_007f, 32'h0800_2a23,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
        // register op with funct3 1 is not decoded
        32'h0660_0093, 32'h0010_0113, 32'h0810_2c23, 32'h0020_91b3,
        32'h0830_2c23, 32'h0010_0073, 32'h0000_0000, 32'h0000_0000
    };
    logic [31:0] exp_adr_tab [NUM_ROWS] = '{32'h84, 32'h88, 32'h90, 32'ha0, 32'h94, 32'h98};
    logic [31:0] exp_data_tab [NUM_ROWS] = '{
        32'hffff_ffe7, 32'h0000_0123, 32'h0000_0043, 32'h0000_1018, 32'h0000_0055, 32'h0000_0066
    };
    logic        exp_illegal_tab [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    int          exp_retire_tab [NUM_ROWS] = '{7, 8, 7, 6, 2, 3};

    rv_core_top #(
        .reset_pc (32'h0)
    ) i_rv_core_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .retire   (retire),
        .halted   (halted),
        .illegal  (illegal)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hbad0_0000 ^ (idx << 2); // byte address mixed in
    endfunction

    // memory slave, acts 1 ns after each rising edge
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                for (int k = 0; k < MEM_WORDS; k++) begin
                    mem[k] = (k < ROW_WORDS) ? code_tab[cur_row*ROW_WORDS + k]
                                             : fill_word(k);
                end
                wb_ack         = 1'b0;
                busy           = 1'b0;
                retire_cnt     = 0;
                cyc_after_stop = 0;
                bad_req_cnt    = 0;
                last_st_adr    = '0;
                last_st_data   = '0;
            end else begin
                if (retire) retire_cnt++;
                if ((halted || illegal) && wb_cyc) cyc_after_stop++;
                if (wb_ack) begin
                    wb_ack = 1'b0;
                end else if (wb_cyc && wb_stb) begin
                    if ((wb_sel != '1) || (wb_adr[1:0] != 2'b00)) begin
                        bad_req_cnt++; // full aligned words only
                    end
                    if (!busy) begin
                        busy      = 1'b1;
                        wait_left = $urandom % (MAX_WAIT + 1);
                    end
                    if (wait_left == 0) begin
                        busy = 1'b0;
                        if (wb_we) begin
                            mem[wb_adr[7:2]] = wb_wdata;
                            last_st_adr      = wb_adr;
                            last_st_data     = wb_wdata;
                        end else begin
                            wb_rdata = mem[wb_adr[7:2]];
                        end
                        wb_ack = 1'b1;
                    end else begin
                        wait_left--;
                    end
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic run_row(input int pass, input int row);
        int errs_before;
        int asrt_before;
        errs_before = err_cnt;
        asrt_before = i_rv_core_top.i_core_ctrl.i_rv_core_properties.assert_fails;
        @(posedge clk);
        #1;
        cur_row = row;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!(halted || illegal)) @(negedge clk);
        repeat (STOP_CYCLES) @(negedge clk); // look for stray bus cycles
        compare("retire count", retire_cnt, exp_retire_tab[row]);
        compare("store address", last_st_adr, exp_adr_tab[row]);
        compare("store data", last_st_data, exp_data_tab[row]);
        compare("halted", halted, !exp_illegal_tab[row]);
        compare("illegal", illegal, exp_illegal_tab[row]);
        compare("bus cycles after stop", cyc_after_stop, 0);
        compare("partial or misaligned accesses", bad_req_cnt, 0);
        compare("assertion failures",
                i_rv_core_top.i_core_ctrl.i_rv_core_properties.assert_fails - asrt_before, 0);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("pass %0d program %0d: ok", pass, row);
        end else begin
            fail_cnt++;
            $display("pass %0d program %0d: FAILED", pass, row);
        end
    endtask

    initial begin
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            for (int row = 0; row < NUM_ROWS; row++) begin
                run_row(pass, row);
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the programs did not stop within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rv_core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_properties (
    input wire                                   clk,
    input wire                                   rst_n,
    input wire  [core_bus_pkg::ADDR_WIDTH-1:0]   wb_adr,
    input wire  [core_bus_pkg::XLEN-1:0]         wb_wdata,
    input wire                                   wb_we,
    input wire                                   wb_cyc,
    input wire                                   wb_stb,
    input wire                                   wb_ack,
    input wire                                   halted,
    input wire                                   illegal
);

    int assert_fails = 0; // failures so far, read by the testbench

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high outside a bus cycle");
            assert_fails++;
        end

    // request fields frozen until the slave answers
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata)))
        else begin
            $error("request changed while waiting for ack");
            assert_fails++;
        end

    a_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && wb_ack) |=> !wb_stb)
        else begin
            $error("wb_stb still high in the cycle after ack");
            assert_fails++;
        end

    a_halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            $error("halted dropped before reset");
            assert_fails++;
        end

    a_illegal_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |=> illegal)
        else begin
            $error("illegal dropped before reset");
            assert_fails++;
        end

    a_quiet_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        (halted || illegal) |-> !wb_cyc)
        else begin
            $error("bus cycle while the core is stopped");
            assert_fails++;
        end

endmodule

bind core_ctrl rv_core_properties i_rv_core_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .halted   (halted),
    .illegal  (illegal)
);

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
    parameter logic [core_bus_pkg::ADDR_WIDTH-1:0] reset_pc = '0
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    output logic [core_bus_pkg::ADDR_WIDTH-1:0]   wb_adr,
    output logic [core_bus_pkg::XLEN-1:0]         wb_wdata,
    output logic [core_bus_pkg::SEL_WIDTH-1:0]    wb_sel,
    output logic                                  wb_we,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    input  wire  [core_bus_pkg::XLEN-1:0]         wb_rdata,
    input  wire                                   wb_ack,
    output logic                                  retire,
    output logic                                  halted,
    output logic                                  illegal
);

    isa_pkg::inst_word_u                  inst;
    isa_pkg::inst_num_e                   inst_num;
    logic [isa_pkg::REG_ADDR_WIDTH-1:0]   rd;
    logic [isa_pkg::REG_ADDR_WIDTH-1:0]   rs1;
    logic [isa_pkg::REG_ADDR_WIDTH-1:0]   rs2;
    logic [core_bus_pkg::XLEN-1:0]        imm;
    logic [core_bus_pkg::XLEN-1:0]        rdata1;
    logic [core_bus_pkg::XLEN-1:0]        rdata2;
    logic [core_bus_pkg::XLEN-1:0]        result;
    logic [core_bus_pkg::XLEN-1:0]        rf_wdata;
    logic                                 rf_we;
    logic [core_bus_pkg::ADDR_WIDTH-1:0]  pc;
    logic [core_bus_pkg::ADDR_WIDTH-1:0]  mem_adr;
    logic [core_bus_pkg::ADDR_WIDTH-1:0]  next_pc;

    core_ctrl #(
        .reset_pc (reset_pc)
    ) i_core_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .inst     (inst),
        .inst_num (inst_num),
        .rd       (rd),
        .result   (result),
        .mem_adr  (mem_adr),
        .next_pc  (next_pc),
        .rdata2   (rdata2),
        .pc       (pc),
        .rf_we    (rf_we),
        .rf_wdata (rf_wdata),
        .retire   (retire),
        .halted   (halted),
        .illegal  (illegal)
    );

    inst_decoder i_inst_decoder (
        .inst      (inst),
        .inst_num  (inst_num),
        .inst_type (), // format only steers the immediate inside the decoder
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .rd     (rd),
        .wdata  (rf_wdata)
    );

    exec_unit i_exec_unit (
        .inst_num (inst_num),
        .pc       (pc),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .imm      (imm),
        .result   (result),
        .mem_adr  (mem_adr),
        .next_pc  (next_pc)
    );

endmodule

`default_nettype wire

// File: design/core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module core_ctrl #(
    parameter logic [core_bus_pkg::ADDR_WIDTH-1:0] reset_pc = '0
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    output logic [core_bus_pkg::ADDR_WIDTH-1:0]   wb_adr,
    output logic [core_bus_pkg::XLEN-1:0]         wb_wdata,
    output logic [core_bus_pkg::SEL_WIDTH-1:0]    wb_sel,
    output logic                                  wb_we,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    input  wire  [core_bus_pkg::XLEN-1:0]         wb_rdata,
    input  wire                                   wb_ack,
    output isa_pkg::inst_word_u                   inst,
    input  wire isa_pkg::inst_num_e               inst_num,
    input  wire  [isa_pkg::REG_ADDR_WIDTH-1:0]    rd,
    input  wire  [core_bus_pkg::XLEN-1:0]         result,
    input  wire  [core_bus_pkg::ADDR_WIDTH-1:0]   mem_adr,
    input  wire  [core_bus_pkg::ADDR_WIDTH-1:0]   next_pc,
    input  wire  [core_bus_pkg::XLEN-1:0]         rdata2,
    output logic [core_bus_pkg::ADDR_WIDTH-1:0]   pc,
    output logic                                  rf_we,
    output logic [core_bus_pkg::XLEN-1:0]         rf_wdata,
    output logic                                  retire,
    output logic                                  halted,
    output logic                                  illegal
);

    localparam logic [2:0] IDLE  = 3'd0; // after reset, and parked once stopped
    localparam logic [2:0] FETCH = 3'd1;
    localparam logic [2:0] EXEC  = 3'd2;
    localparam logic [2:0] MEM   = 3'd3;
    localparam logic [2:0] WB    = 3'd4;

    logic [2:0]                    state;
    logic [core_bus_pkg::XLEN-1:0] load_q;
    logic                          bus_req;
    logic                          is_mem;
    logic                          writes_rd;

    assign is_mem = (inst_num == isa_pkg::lw) || (inst_num == isa_pkg::sw);

    always_comb begin
        case (inst_num)
            isa_pkg::auipc,
            isa_pkg::jal,
            isa_pkg::jalr,
            isa_pkg::lw,
            isa_pkg::addi,
            isa_pkg::add,
            isa_pkg::sub: writes_rd = (rd != '0);
            default:      writes_rd = 1'b0;
        endcase
    end

    // request held for the whole fetch or data step, so all fields stay put until ack
    assign bus_req  = (state == FETCH) || (state == MEM);
    assign wb_cyc   = bus_req;
    assign wb_stb   = bus_req;
    assign wb_we    = (state == MEM) && (inst_num == isa_pkg::sw);
    assign wb_adr   = (state == MEM) ? mem_adr : pc;
    assign wb_wdata = rdata2;
    assign wb_sel   = '1; // word accesses only

    assign rf_we    = (state == WB) && writes_rd;
    assign rf_wdata = (inst_num == isa_pkg::lw) ? load_q : result;
    assign retire   = (state == WB);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            pc      <= reset_pc;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!halted && !illegal) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (wb_ack) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (inst_num == isa_pkg::inv) begin
                        illegal <= 1'b1; // stop without retiring
                        state   <= IDLE;
                    end else if (is_mem) begin
                        state <= MEM;
                    end else begin
                        if (inst_num == isa_pkg::ebreak) begin
                            halted <= 1'b1; // high during its WB
                        end
                        state <= WB;
                    end
                end
                MEM: begin
                    if (wb_ack) begin
                        state <= WB;
                    end
                end
                WB: begin
                    pc    <= next_pc;
                    state <= halted ? IDLE : FETCH;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == FETCH) && wb_ack) begin
            inst <= wb_rdata;
        end
        if ((state == MEM) && wb_ack) begin
            load_q <= wb_rdata; // only used by lw
        end
    end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  wire isa_pkg::inst_num_e                   inst_num,
    input  wire  [core_bus_pkg::ADDR_WIDTH-1:0]       pc,
    input  wire  [core_bus_pkg::XLEN-1:0]             rdata1,
    input  wire  [core_bus_pkg::XLEN-1:0]             rdata2,
    input  wire  [core_bus_pkg::XLEN-1:0]             imm,
    output logic [core_bus_pkg::XLEN-1:0]             result,
    output logic [core_bus_pkg::ADDR_WIDTH-1:0]       mem_adr,
    output logic [core_bus_pkg::ADDR_WIDTH-1:0]       next_pc
);

    logic                                 is_sub;
    logic [core_bus_pkg::XLEN-1:0]        alu_b;
    logic [core_bus_pkg::XLEN-1:0]        alu_sum;
    logic [core_bus_pkg::ADDR_WIDTH-1:0]  pc_plus4;
    logic [core_bus_pkg::ADDR_WIDTH-1:0]  pc_plus_imm;
    logic [core_bus_pkg::XLEN-1:0]        rs1_plus_imm;
    logic                                 operands_eq;

    assign is_sub = (inst_num == isa_pkg::sub);

    // shared adder for add, sub and addi
    always_comb begin
        if (is_sub) begin
            alu_b = ~rdata2; // two's complement with carry-in below
        end else if (inst_num == isa_pkg::addi) begin
            alu_b = imm;
        end else begin
            alu_b = rdata2;
        end
    end

    assign alu_sum      = rdata1 + alu_b + core_bus_pkg::XLEN'(is_sub);
    assign pc_plus4     = pc + core_bus_pkg::ADDR_WIDTH'(4);
    assign pc_plus_imm  = pc + imm;
    assign rs1_plus_imm = rdata1 + imm;
    assign operands_eq  = (rdata1 == rdata2);

    assign mem_adr = rs1_plus_imm;

    always_comb begin
        case (inst_num)
            isa_pkg::add,
            isa_pkg::sub,
            isa_pkg::addi:  result = alu_sum;
            isa_pkg::auipc: result = pc_plus_imm;
            isa_pkg::jal,
            isa_pkg::jalr:  result = pc_plus4; // link address
            default:        result = '0;
        endcase
    end

    always_comb begin
        case (inst_num)
            isa_pkg::jal:  next_pc = pc_plus_imm;
            isa_pkg::jalr: next_pc = {rs1_plus_imm[core_bus_pkg::ADDR_WIDTH-1:1], 1'b0};
            isa_pkg::beq:  next_pc = operands_eq ? pc_plus_imm : pc_plus4;
            default:       next_pc = pc_plus4;
        endcase
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  [isa_pkg::REG_ADDR_WIDTH-1:0]    rs1,
    input  wire  [isa_pkg::REG_ADDR_WIDTH-1:0]    rs2,
    output logic [core_bus_pkg::XLEN-1:0]         rdata1,
    output logic [core_bus_pkg::XLEN-1:0]         rdata2,
    input  wire                                   we,
    input  wire  [isa_pkg::REG_ADDR_WIDTH-1:0]    rd,
    input  wire  [core_bus_pkg::XLEN-1:0]         wdata
);

    localparam int NUM_REGS = 2 ** isa_pkg::REG_ADDR_WIDTH;

    logic [core_bus_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 never written, so it reads zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  wire isa_pkg::inst_word_u                  inst,
    output isa_pkg::inst_num_e                        inst_num,
    output isa_pkg::inst_type_e                       inst_type,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0]        rd,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0]        rs1,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0]        rs2,
    output logic [core_bus_pkg::XLEN-1:0]             imm
);

    logic [11:0] imm_hi;
    logic [4:0]  imm_mid;
    logic [2:0]  imm_f3;
    logic [4:0]  imm_lo;
    logic        alt_op;

    assign imm_hi  = inst.imm_fmt.imm_hi;
    assign imm_mid = inst.imm_fmt.imm_mid;
    assign imm_f3  = inst.imm_fmt.funct3;
    assign imm_lo  = inst.imm_fmt.imm_lo;
    assign alt_op  = inst.r_fmt.funct7[5]; // instruction bit 30

    assign rd  = inst.r_fmt.rd;
    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;

    always_comb begin
        inst_num  = isa_pkg::inv;
        inst_type = isa_pkg::N;
        case (inst.r_fmt.opcode)
            isa_pkg::OP_AUIPC: begin
                inst_num  = isa_pkg::auipc;
                inst_type = isa_pkg::U;
            end
            isa_pkg::OP_JAL: begin
                inst_num  = isa_pkg::jal;
                inst_type = isa_pkg::J;
            end
            isa_pkg::OP_JALR: begin
                inst_num  = isa_pkg::jalr;
                inst_type = isa_pkg::I;
            end
            isa_pkg::OP_BRANCH: begin
                inst_num  = isa_pkg::beq;
                inst_type = isa_pkg::B;
            end
            isa_pkg::OP_LOAD: begin
                inst_num  = isa_pkg::lw;
                inst_type = isa_pkg::I;
            end
            isa_pkg::OP_STORE: begin
                inst_num  = isa_pkg::sw;
                inst_type = isa_pkg::S;
            end
            isa_pkg::OP_IMM: begin
                inst_num  = isa_pkg::addi;
                inst_type = isa_pkg::I;
            end
            isa_pkg::OP_REG: begin
                inst_type = isa_pkg::R;
                if (inst.r_fmt.funct3 == isa_pkg::F3_ADD_SUB) begin
                    if (alt_op) begin
                        inst_num = isa_pkg::sub;
                    end else begin
                        inst_num = isa_pkg::add;
                    end
                end
            end
            isa_pkg::OP_SYSTEM: begin
                inst_num  = isa_pkg::ebreak; // funct12 not checked
                inst_type = isa_pkg::I;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst_type)
            isa_pkg::I: imm = {{20{imm_hi[11]}}, imm_hi};
            isa_pkg::S: imm = {{20{imm_hi[11]}}, imm_hi[11:5], imm_lo};
            isa_pkg::B: imm = {{20{imm_hi[11]}}, imm_lo[0], imm_hi[10:5], imm_lo[4:1], 1'b0};
            isa_pkg::U: imm = {imm_hi, imm_mid, imm_f3, 12'b0};
            isa_pkg::J: imm = {{12{imm_hi[11]}}, imm_mid, imm_f3, imm_hi[0], imm_hi[10:1], 1'b0};
            default:    imm = '0; // R and invalid
        endcase
    end

endmodule

`default_nettype wire

// File: design/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    localparam int XLEN       = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int SEL_WIDTH  = XLEN / 8; // one select bit per byte lane

endpackage

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPCODE_WIDTH   = 7;
    localparam int FUNCT3_WIDTH   = 3;

    localparam logic [OPCODE_WIDTH-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_WIDTH-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OP_SYSTEM = 7'b1110011;

    localparam logic [FUNCT3_WIDTH-1:0] F3_ADD_SUB = 3'b000; // only funct3 known for OP_REG

    typedef enum logic [3:0] {
        inv,
        auipc,
        jal,
        jalr,
        beq,
        lw,
        sw,
        addi,
        add,
        sub,
        ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        N,
        R,
        I,
        S,
        B,
        U,
        J
    } inst_type_e;

    // same 32 bits, seen as register fields or as immediate slices
    typedef union packed {
        struct packed {
            logic [6:0]                funct7;
            logic [REG_ADDR_WIDTH-1:0] rs2;
            logic [REG_ADDR_WIDTH-1:0] rs1;
            logic [FUNCT3_WIDTH-1:0]   funct3;
            logic [REG_ADDR_WIDTH-1:0] rd;
            logic [OPCODE_WIDTH-1:0]   opcode;
        } r_fmt;
        struct packed {
            logic [11:0]               imm_hi;  // bits 31:20
            logic [4:0]                imm_mid; // bits 19:15
            logic [FUNCT3_WIDTH-1:0]   funct3;
            logic [4:0]                imm_lo;  // bits 11:7
            logic [OPCODE_WIDTH-1:0]   opcode;
        } imm_fmt;
    } inst_word_u;

endpackage

`default_nettype wire
